/* rtl/dkjr_snd_pkg.sv */
//==========================================================================
// Sample sound package
// Voice encoding, widths, sample table and walk/climb multi-sample order
//==========================================================================

package dkjr_snd_pkg;

	// Voice index, also the owner of a wave ROM slot
	typedef enum logic [1:0] {
		WALK = 2'd0,
		JUMP = 2'd1,
		LAND = 2'd2,
		FALL = 2'd3
	} voice_e;

	localparam int NUM_VOICES = 4;
	localparam int SAMPLE_W   = 16;
	localparam int WAV_ADDR_W = 16;
	localparam int VOL_W      = 4;
	localparam int MIX_W      = 19;
	localparam int SLOT_W     = 4;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic [WAV_ADDR_W-1:0]      wav_addr_t;

	//======================================================================
	// Sample table, indexed by voice_e
	//======================================================================

	// WALK start is only the base of the walk blocks
	localparam wav_addr_t VOICE_START [NUM_VOICES] = '{
		16'h0000, 16'h3000, 16'h5000, 16'h7000
	};

	// Length in samples
	localparam wav_addr_t VOICE_LEN [NUM_VOICES] = '{
		16'h0800, 16'h2000, 16'h2000, 16'h5000
	};

	// Walk block order, one entry per walk trigger
	localparam logic [2:0] WALK_SEQ [7] = '{
		3'd1, 3'd2, 3'd1, 3'd2, 3'd0, 3'd1, 3'd0
	};

	// Climb blocks sit three blocks above the walk blocks
	localparam int WALK_CLIMB_OFS   = 3;
	localparam int WALK_BLOCK_SHIFT = 11;

endpackage

/* rtl/wave_fetch_if.sv */
//==========================================================================
// Wave fetch interface
// One voice requests a ROM word, the arbiter returns it with take
//==========================================================================

`timescale 1ns/1ps

interface wave_fetch_if;
	import dkjr_snd_pkg::*;

	// Word address, held by the voice while pend is high
	wav_addr_t addr;
	logic      pend;

	// ROM word, valid in the take cycle only
	sample_t   data;
	logic      take;

	modport voice (
		output addr,
		output pend,
		input  data,
		input  take
	);

	modport arbiter (
		input  addr,
		input  pend,
		output data,
		output take
	);

endinterface

/* rtl/snd_trigger_decode.sv */
//==========================================================================
// Sound latch trigger decode
// Turns latch edges into voice start pulses, picks the walk/climb block
//==========================================================================

`timescale 1ns/1ps

module snd_trigger_decode (
	input  logic                                W_CLK_12288M,
	input  logic                                W_RESETn,
	input  logic                                walk_n,
	input  logic                                climb,
	input  logic                                jump_n,
	input  logic                                land_n,
	input  logic                                fall,
	output logic [dkjr_snd_pkg::NUM_VOICES-1:0] start,
	output logic                                fall_stop,
	output dkjr_snd_pkg::wav_addr_t             walk_addr
);
	import dkjr_snd_pkg::*;

	logic [NUM_VOICES-1:0] trig_lvl;
	logic [NUM_VOICES-1:0] trig_q;
	logic [NUM_VOICES-1:0] trig_qq;
	logic [NUM_VOICES-1:0] rise;
	logic                  climb_q;
	logic [2:0]            seq_idx;
	logic [2:0]            walk_sel;

	// Active high trigger levels, one bit per voice
	assign trig_lvl[WALK] = ~walk_n;
	assign trig_lvl[JUMP] = ~jump_n;
	assign trig_lvl[LAND] = ~land_n;
	assign trig_lvl[FALL] = fall;

	assign rise = trig_q & ~trig_qq;

	// Block number, moved up to the climb blocks when climb is low
	assign walk_sel = WALK_SEQ[seq_idx] + (climb_q ? 3'd0 : 3'(WALK_CLIMB_OFS));

	always_ff @(posedge W_CLK_12288M or negedge W_RESETn) begin
		if (!W_RESETn) begin
			trig_q    <= '0;
			trig_qq   <= '0;
			climb_q   <= 1'b0;
			seq_idx   <= 3'd0;
			start     <= '0;
			fall_stop <= 1'b0;
			walk_addr <= '0;
		end else begin
			trig_q    <= trig_lvl;
			trig_qq   <= trig_q;
			climb_q   <= climb;
			start     <= rise;
			fall_stop <= trig_qq[FALL] & ~trig_q[FALL];

			// Next multi-sample on each walk edge
			if (rise[WALK]) begin
				seq_idx   <= (seq_idx == 3'd6) ? 3'd0 : seq_idx + 3'd1;
				walk_addr <= wav_addr_t'(walk_sel) << WALK_BLOCK_SHIFT;
			end
		end
	end

	// Each start is a single-cycle pulse
	a_start_pulse: assert property (@(posedge W_CLK_12288M) disable iff (!W_RESETn)
		(start & $past(start)) == '0)
		else $error("start held for more than one cycle: %b", start);

endmodule

/* rtl/snd_voice.sv */
//==========================================================================
// Sample voice
// Steps through one sample in wave ROM, one word per tick, scaled by volume
//==========================================================================

`timescale 1ns/1ps

module snd_voice #(
	parameter dkjr_snd_pkg::voice_e VOICE = dkjr_snd_pkg::WALK
) (
	input  logic                           W_CLK_12288M,
	input  logic                           W_RESETn,
	input  logic                           start,
	input  logic                           stop,
	input  logic                           tick,
	input  logic [dkjr_snd_pkg::VOL_W-1:0] volume,
	input  dkjr_snd_pkg::wav_addr_t        walk_addr,
	wave_fetch_if.voice                    fetch,
	output dkjr_snd_pkg::sample_t          snd
);
	import dkjr_snd_pkg::*;

	logic                           active;
	logic                           pend;
	wav_addr_t                      addr;
	wav_addr_t                      remain;
	wav_addr_t                      start_addr;
	logic                           take;
	logic signed [SAMPLE_W+VOL_W:0] product;
	sample_t                        scaled;

	// Walk start comes from the multi-sample selector
	assign start_addr = (VOICE == WALK) ? walk_addr : VOICE_START[VOICE];

	// A take after a restart belongs to the old request
	assign take = fetch.take & pend;

	// Volume 0..15 in 1/16 steps
	assign product = fetch.data * $signed({1'b0, volume});
	assign scaled  = product[SAMPLE_W+VOL_W-1:VOL_W];

	assign fetch.addr = addr;
	assign fetch.pend = pend;

	always_ff @(posedge W_CLK_12288M or negedge W_RESETn) begin
		if (!W_RESETn) begin
			active <= 1'b0;
			pend   <= 1'b0;
			addr   <= '0;
			remain <= '0;
			snd    <= '0;
		end else if (stop) begin
			active <= 1'b0;
			pend   <= 1'b0;
			snd    <= '0;
		end else if (start) begin
			active <= 1'b1;
			pend   <= 1'b0;
			addr   <= start_addr;
			remain <= VOICE_LEN[VOICE];
		end else if (take) begin
			pend   <= 1'b0;
			snd    <= scaled;
			addr   <= addr + 1'b1;
			remain <= remain - 1'b1;
		end else if (active && remain == '0) begin
			// End of sample
			active <= 1'b0;
			snd    <= '0;
		end else if (tick && active) begin
			pend <= 1'b1;
		end
	end

	// The arbiter may capture addr in any cycle of the request
	a_addr_hold: assert property (@(posedge W_CLK_12288M) disable iff (!W_RESETn)
		pend |=> (!pend || $stable(addr)))
		else $error("voice %0d moved addr during a request", VOICE);

endmodule

/* rtl/wave_rom_arbiter.sv */
//==========================================================================
// Wave ROM arbiter
// Shares one registered ROM port among the voices by fixed time slots
//==========================================================================

`timescale 1ns/1ps

module wave_rom_arbiter (
	input  logic                    W_CLK_12288M,
	input  logic                    W_RESETn,
	input  dkjr_snd_pkg::sample_t   wav_data,
	output dkjr_snd_pkg::wav_addr_t wav_addr,
	wave_fetch_if.arbiter           fetch [dkjr_snd_pkg::NUM_VOICES]
);
	import dkjr_snd_pkg::*;

	logic [SLOT_W-1:0]     slot;
	logic                  own_slot;
	voice_e                owner;
	logic [NUM_VOICES-1:0] pend;
	wav_addr_t             addr [NUM_VOICES];
	logic [NUM_VOICES-1:0] take;
	logic                  issue_v;
	voice_e                issue_id;
	logic                  read_v;
	voice_e                read_id;

	// Slots 0, 2, 4 and 6 belong to voices 0..3, the rest are idle
	assign own_slot = (slot[SLOT_W-1:3] == '0) && !slot[0];
	assign owner    = voice_e'(slot[2:1]);

	for (genvar i = 0; i < NUM_VOICES; i++) begin : g_port
		assign pend[i]       = fetch[i].pend;
		assign addr[i]       = fetch[i].addr;
		assign take[i]       = read_v && (read_id == voice_e'(i));
		assign fetch[i].take = take[i];
		assign fetch[i].data = wav_data;
	end

	// Address out, ROM read, then take two slots after the grant
	always_ff @(posedge W_CLK_12288M or negedge W_RESETn) begin
		if (!W_RESETn) begin
			slot     <= '0;
			issue_v  <= 1'b0;
			issue_id <= WALK;
			read_v   <= 1'b0;
			read_id  <= WALK;
			wav_addr <= '0;
		end else begin
			slot     <= slot + 1'b1;
			issue_v  <= own_slot && pend[owner];
			issue_id <= owner;
			read_v   <= issue_v;
			read_id  <= issue_id;
			if (own_slot && pend[owner]) begin
				wav_addr <= addr[owner];
			end
		end
	end

	a_one_take: assert property (@(posedge W_CLK_12288M) disable iff (!W_RESETn)
		$onehot0(take))
		else $error("more than one take: %b", take);

endmodule

/* rtl/snd_voice_bank.sv */
//==========================================================================
// Sample voice bank
// Sample rate divider, the four voices and their shared wave ROM port
//==========================================================================

`timescale 1ns/1ps

module snd_voice_bank #(
	parameter int unsigned SAMPLE_DIV = 1115
) (
	input  logic                                W_CLK_12288M,
	input  logic                                W_RESETn,
	input  logic [dkjr_snd_pkg::NUM_VOICES-1:0] start,
	input  logic                                fall_stop,
	input  dkjr_snd_pkg::wav_addr_t             walk_addr,
	input  logic [dkjr_snd_pkg::VOL_W-1:0]      volume,
	input  dkjr_snd_pkg::sample_t               wav_data,
	output dkjr_snd_pkg::wav_addr_t             wav_addr,
	output dkjr_snd_pkg::sample_t               voice_snd [dkjr_snd_pkg::NUM_VOICES]
);
	import dkjr_snd_pkg::*;

	logic [$clog2(SAMPLE_DIV)-1:0] div_cnt;
	logic                          tick;

	wave_fetch_if fetch [NUM_VOICES] ();

	//======================================================================
	// Sample rate divider
	//======================================================================

	assign tick = (div_cnt == SAMPLE_DIV - 1);

	always_ff @(posedge W_CLK_12288M or negedge W_RESETn) begin
		if (!W_RESETn) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
		end
	end

	//======================================================================
	// Voices and ROM port
	//======================================================================

	for (genvar v = 0; v < NUM_VOICES; v++) begin : g_voice
		// Only the fall sound stops on its latch going low
		snd_voice #(
			.VOICE(voice_e'(v))
		) i_voice (
			.W_CLK_12288M (W_CLK_12288M),
			.W_RESETn     (W_RESETn),
			.start        (start[v]),
			.stop         ((voice_e'(v) == FALL) ? fall_stop : 1'b0),
			.tick         (tick),
			.volume       (volume),
			.walk_addr    (walk_addr),
			.fetch        (fetch[v]),
			.snd          (voice_snd[v])
		);
	end

	wave_rom_arbiter i_arbiter (
		.W_CLK_12288M (W_CLK_12288M),
		.W_RESETn     (W_RESETn),
		.wav_data     (wav_data),
		.wav_addr     (wav_addr),
		.fetch        (fetch)
	);

endmodule

/* rtl/snd_mix_limit.sv */
//==========================================================================
// Sound mixer
// Adds the sample voices to the digital sound and clamps to 16 bits
//==========================================================================

`timescale 1ns/1ps

module snd_mix_limit (
	input  logic                  W_CLK_12288M,
	input  logic                  W_RESETn,
	input  dkjr_snd_pkg::sample_t voice_snd [dkjr_snd_pkg::NUM_VOICES],
	input  dkjr_snd_pkg::sample_t digital_snd,
	output dkjr_snd_pkg::sample_t snd_out
);
	import dkjr_snd_pkg::*;

	logic signed [MIX_W-1:0] mix;

	// Five signed terms, sign extended so the sum cannot wrap
	always_comb begin
		mix = MIX_W'(digital_snd);
		for (int i = 0; i < NUM_VOICES; i++) begin
			mix = mix + MIX_W'(voice_snd[i]);
		end
	end

	// Positive and negative limiter
	always_ff @(posedge W_CLK_12288M or negedge W_RESETn) begin
		if (!W_RESETn) begin
			snd_out <= '0;
		end else if (mix >= MIX_W'(16'sh7FFF)) begin
			snd_out <= 16'sh7FFF;
		end else if (mix <= MIX_W'(16'sh8000)) begin
			snd_out <= 16'sh8000;
		end else begin
			snd_out <= mix[SAMPLE_W-1:0];
		end
	end

endmodule

/* rtl/dkjr_sample_sound.sv */
//==========================================================================
// Donkey Kong Jr sample sound
// Walk/climb, jump, land and fall samples mixed with the digital sound
//==========================================================================

`timescale 1ns/1ps

module dkjr_sample_sound #(
	// 12.288 MHz / 1115, about 11 kHz
	parameter int unsigned SAMPLE_DIV = 1115
) (
	input  logic                           W_CLK_12288M,
	input  logic                           W_RESETn,
	input  logic                           walk_n,
	input  logic                           climb,
	input  logic                           jump_n,
	input  logic                           land_n,
	input  logic                           fall,
	input  logic [dkjr_snd_pkg::VOL_W-1:0] volume,
	input  dkjr_snd_pkg::sample_t          digital_snd,
	output dkjr_snd_pkg::wav_addr_t        wav_addr,
	input  dkjr_snd_pkg::sample_t          wav_data,
	output dkjr_snd_pkg::sample_t          snd_out
);
	import dkjr_snd_pkg::*;

	logic [NUM_VOICES-1:0] start;
	logic                  fall_stop;
	wav_addr_t             walk_addr;
	sample_t               voice_snd [NUM_VOICES];

	snd_trigger_decode i_trigger_decode (
		.W_CLK_12288M (W_CLK_12288M),
		.W_RESETn     (W_RESETn),
		.walk_n       (walk_n),
		.climb        (climb),
		.jump_n       (jump_n),
		.land_n       (land_n),
		.fall         (fall),
		.start        (start),
		.fall_stop    (fall_stop),
		.walk_addr    (walk_addr)
	);

	snd_voice_bank #(
		.SAMPLE_DIV(SAMPLE_DIV)
	) i_voice_bank (
		.W_CLK_12288M (W_CLK_12288M),
		.W_RESETn     (W_RESETn),
		.start        (start),
		.fall_stop    (fall_stop),
		.walk_addr    (walk_addr),
		.volume       (volume),
		.wav_data     (wav_data),
		.wav_addr     (wav_addr),
		.voice_snd    (voice_snd)
	);

	snd_mix_limit i_mix_limit (
		.W_CLK_12288M (W_CLK_12288M),
		.W_RESETn     (W_RESETn),
		.voice_snd    (voice_snd),
		.digital_snd  (digital_snd),
		.snd_out      (snd_out)
	);

endmodule

/* sim/wave_rom_model.sv */
//==========================================================================
// Wave ROM model
// Registered read, one cycle after the address, word is address XOR A5C3
//==========================================================================

`timescale 1ns/1ps

module wave_rom_model (
	input  logic                    W_CLK_12288M,
	input  logic                    W_RESETn,
	input  dkjr_snd_pkg::wav_addr_t addr,
	output dkjr_snd_pkg::sample_t   data
);
	import dkjr_snd_pkg::*;

	// Every address bit shows up in the word
	localparam wav_addr_t FILL = 16'hA5C3;

	always_ff @(posedge W_CLK_12288M or negedge W_RESETn) begin
		if (!W_RESETn) begin
			data <= '0;
		end else begin
			data <= addr ^ FILL;
		end
	end

endmodule

/* sim/tb_dkjr_sample_sound.sv */
//==========================================================================
// Testbench for the sample sound section
// Directed tests of triggers, ROM fetch, scaling, mixing and limiting
//==========================================================================

`timescale 1ns/1ps

module tb_dkjr_sample_sound;
	import dkjr_snd_pkg::*;

	localparam int DIV        = 64;
	localparam int CHECK_OFS  = 40;
	// Long fall run and walk end test together are about 393k cycles
	localparam int MAX_CYCLES = 400000;

	localparam int VOICE_BASE [4]    = '{'h0000, 'h3000, 'h5000, 'h7000};
	localparam int VOICE_SAMPLES [4] = '{'h0800, 'h2000, 'h2000, 'h5000};
	localparam int WALK_ORDER [7]    = '{1, 2, 1, 2, 0, 1, 0};

	logic             W_CLK_12288M;
	logic             W_RESETn;
	logic             walk_n;
	logic             climb;
	logic             jump_n;
	logic             land_n;
	logic             fall;
	logic [VOL_W-1:0] volume;
	sample_t          digital_snd;
	wav_addr_t        wav_addr;
	sample_t          wav_data;
	sample_t          snd_out;

	// Cycles since reset release, and since time 0
	int cyc     = 0;
	int run_cyc = 0;

	// Expected voice state
	bit exp_active [4];
	int exp_addr [4];
	int exp_remain [4];
	int exp_out [4];
	int walk_idx;

	dkjr_sample_sound #(
		.SAMPLE_DIV(DIV)
	) i_dkjr_sample_sound (
		.W_CLK_12288M (W_CLK_12288M),
		.W_RESETn     (W_RESETn),
		.walk_n       (walk_n),
		.climb        (climb),
		.jump_n       (jump_n),
		.land_n       (land_n),
		.fall         (fall),
		.volume       (volume),
		.digital_snd  (digital_snd),
		.wav_addr     (wav_addr),
		.wav_data     (wav_data),
		.snd_out      (snd_out)
	);

	wave_rom_model i_wave_rom (
		.W_CLK_12288M (W_CLK_12288M),
		.W_RESETn     (W_RESETn),
		.addr         (wav_addr),
		.data         (wav_data)
	);

	initial begin
		W_CLK_12288M = 1'b0;
		forever #2 W_CLK_12288M = ~W_CLK_12288M;
	end

	always @(posedge W_CLK_12288M) begin
		run_cyc = run_cyc + 1;
		cyc = W_RESETn ? cyc + 1 : 0;
		if (run_cyc >= MAX_CYCLES) begin
			$display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST FAIL");
			$fatal(1, "run stopped by timeout");
		end
	end

	//======================================================================
	// Checker and reference model
	//======================================================================

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s: expected 0x%04h, got 0x%04h", name, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// ROM word times volume, arithmetic shift right by 4
	function automatic int scaled_word(input int addr, input logic [3:0] vol);
		logic signed [15:0] word;
		word = 16'(addr) ^ 16'hA5C3;
		return (int'(word) * int'(vol)) >>> 4;
	endfunction

	function automatic logic [15:0] expected_out(input int digital);
		int sum;
		sum = digital;
		for (int v = 0; v < 4; v++) begin
			sum = sum + exp_out[v];
		end
		if (sum > 32767) begin
			sum = 32767;
		end else if (sum < -32768) begin
			sum = -32768;
		end
		return 16'(sum);
	endfunction

	// Wait for the next check point, apply the tick before it, compare
	task automatic next_sample();
		do begin
			@(posedge W_CLK_12288M);
			#1;
		end while ((cyc % DIV) != CHECK_OFS);
		if (cyc > DIV) begin
			for (int v = 0; v < 4; v++) begin
				if (exp_active[v]) begin
					exp_remain[v] = exp_remain[v] - 1;
					if (exp_remain[v] == 0) begin
						exp_active[v] = 1'b0;
						exp_out[v] = 0;
					end else begin
						exp_out[v] = scaled_word(exp_addr[v], volume);
					end
					exp_addr[v] = exp_addr[v] + 1;
				end
			end
		end
		check_value("snd_out", expected_out(int'(digital_snd)), snd_out);
	endtask

	//======================================================================
	// Stimulus helpers
	//======================================================================

	task automatic apply_reset();
		W_RESETn    = 1'b0;
		walk_n      = 1'b1;
		climb       = 1'b1;
		jump_n      = 1'b1;
		land_n      = 1'b1;
		fall        = 1'b0;
		volume      = '0;
		digital_snd = '0;
		for (int v = 0; v < 4; v++) begin
			exp_active[v] = 1'b0;
			exp_out[v] = 0;
		end
		walk_idx = 0;
		repeat (16) @(posedge W_CLK_12288M);
		#1;
		W_RESETn = 1'b1;
		// First check point has no tick before it
		next_sample();
	endtask

	// Strobe one active low latch and start the expected voice
	task automatic latch_strobe(input voice_e v, input int addr);
		exp_active[v] = 1'b1;
		exp_addr[v]   = addr;
		exp_remain[v] = VOICE_SAMPLES[v];
		walk_n = (v != WALK);
		jump_n = (v != JUMP);
		land_n = (v != LAND);
		repeat (4) @(posedge W_CLK_12288M);
		#1;
		walk_n = 1'b1;
		jump_n = 1'b1;
		land_n = 1'b1;
	endtask

	task automatic walk_edge(input logic climb_lvl);
		int block;
		climb = climb_lvl;
		block = WALK_ORDER[walk_idx] + (climb_lvl ? 0 : 3);
		walk_idx = (walk_idx == 6) ? 0 : walk_idx + 1;
		latch_strobe(WALK, block << 11);
	endtask

	task automatic set_fall(input logic lvl);
		fall = lvl;
		exp_active[FALL] = lvl;
		exp_addr[FALL]   = VOICE_BASE[FALL];
		exp_remain[FALL] = VOICE_SAMPLES[FALL];
		if (!lvl) begin
			exp_out[FALL] = 0;
		end
	endtask

	//======================================================================
	// Directed tests
	//======================================================================

	task automatic test_reset_state();
		apply_reset();
		check_value("wav_addr", 16'h0000, wav_addr);
		next_sample();
		check_value("wav_addr", 16'h0000, wav_addr);
	endtask

	task automatic test_jump_land();
		apply_reset();
		volume = 4'd15;
		latch_strobe(JUMP, VOICE_BASE[JUMP]);
		for (int i = 0; i < 5; i++) begin
			next_sample();
			check_value("wav_addr", 16'(VOICE_BASE[JUMP] + i), wav_addr);
		end
		latch_strobe(LAND, VOICE_BASE[LAND]);
		for (int i = 0; i < 3; i++) begin
			next_sample();
			check_value("wav_addr", 16'(VOICE_BASE[LAND] + i), wav_addr);
		end
	endtask

	task automatic test_walk_select();
		logic [8:0] climb_pat;
		apply_reset();
		volume = 4'd15;
		climb_pat = 9'b1_0110_0101;
		for (int e = 0; e < 9; e++) begin
			walk_edge(climb_pat[e]);
			next_sample();
			check_value("wav_addr", 16'(exp_addr[WALK] - 1), wav_addr);
			next_sample();
		end
	endtask

	task automatic test_fall();
		apply_reset();
		volume = 4'd15;
		set_fall(1'b1);
		repeat (3) next_sample();
		set_fall(1'b0);
		next_sample();
		set_fall(1'b1);
		next_sample();
		check_value("wav_addr", 16'(VOICE_BASE[FALL]), wav_addr);
		next_sample();
	endtask

	task automatic test_volume_digital();
		apply_reset();
		latch_strobe(JUMP, VOICE_BASE[JUMP]);
		set_fall(1'b1);
		for (int i = 0; i < 8; i++) begin
			volume = 4'($urandom);
			digital_snd = 16'($urandom);
			next_sample();
		end
		volume = 4'd15;
		digital_snd = 16'h7F00;
		next_sample();
		digital_snd = 16'h8100;
		next_sample();
		check_value("snd_out", 16'h8000, snd_out);
		// Fall words turn positive from ROM address 0x8000 on
		digital_snd = 16'h7F00;
		while (exp_addr[FALL] < 'h8000) begin
			next_sample();
		end
		next_sample();
		check_value("snd_out", 16'h7FFF, snd_out);
	endtask

	task automatic test_sample_end();
		apply_reset();
		volume = 4'd15;
		digital_snd = 16'h1234;
		walk_edge(1'b1);
		repeat (VOICE_SAMPLES[WALK]) next_sample();
		check_value("snd_out", 16'h1234, snd_out);
		next_sample();
	endtask

	initial begin
		int seed;
		seed = $urandom(32'h92fedf37);
		W_RESETn    = 1'b0;
		walk_n      = 1'b1;
		climb       = 1'b1;
		jump_n      = 1'b1;
		land_n      = 1'b1;
		fall        = 1'b0;
		volume      = '0;
		digital_snd = '0;
		test_reset_state();
		test_jump_land();
		test_walk_select();
		test_fall();
		test_volume_digital();
		test_sample_end();
		$display("TEST PASS");
		$finish;
	end

endmodule

/* list.f */
rtl/dkjr_snd_pkg.sv
rtl/wave_fetch_if.sv
rtl/snd_trigger_decode.sv
rtl/snd_voice.sv
rtl/wave_rom_arbiter.sv
rtl/snd_voice_bank.sv
rtl/snd_mix_limit.sv
rtl/dkjr_sample_sound.sv
sim/wave_rom_model.sv
sim/tb_dkjr_sample_sound.sv

/* Bender.yml */
package:
  name: dkjr_sample_sound

sources:
  # Design, in compile order
  - rtl/dkjr_snd_pkg.sv
  - rtl/wave_fetch_if.sv
  - rtl/snd_trigger_decode.sv
  - rtl/snd_voice.sv
  - rtl/wave_rom_arbiter.sv
  - rtl/snd_voice_bank.sv
  - rtl/snd_mix_limit.sv
  - rtl/dkjr_sample_sound.sv

  # Testbench and ROM model
  - target: simulation
    files:
      - sim/wave_rom_model.sv
      - sim/tb_dkjr_sample_sound.sv
